//--- list.f
sdram_pkg.sv
sdram_init.sv
sdram_refresh.sv
sdram_access.sv
sdram_ctrl.sv
tb_clock.sv
tb_sdram_model.sv
tb_sdram_ctrl.sv

//--- Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --assert
TOP       = tb_sdram_ctrl
FILELIST  = list.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

//--- tb_sdram_ctrl.sv
`timescale 1ns/10ps
// SDRAM controller testbench

module tb_sdram_ctrl;

    localparam int N_DIRECTED = 9;
    localparam int N_RANDOM   = 200;
    localparam int WD_CYCLES  = sdram_pkg::POWERUP_WAIT + 60 + 40 * (N_DIRECTED + N_RANDOM);
    localparam int MAX_REF_GAP = sdram_pkg::REFRESH_INTERVAL + sdram_pkg::T_RCD +
                                 sdram_pkg::CAS_LAT + sdram_pkg::T_WR_AP + 4;

    logic                  clk;
    logic                  rst;
    logic                  req_valid;
    sdram_pkg::host_req_t  req;
    logic                  credit_return;
    logic                  rd_valid;
    logic [15:0]           rd_data;
    logic                  init_done;
    sdram_pkg::sdram_bus_t sdram_bus;
    logic [15:0]           dq_out;
    logic                  dq_oe;
    logic [15:0]           dq_in;

    integer      seed;
    int          credits;
    logic [15:0] sb [logic [23:0]];  // scoreboard memory
    logic [15:0] exp_q [$];          // expected read data, request order

    // monitor state
    int  cyc;
    int  init_step;
    int  last_init;
    bit  done_seen;
    bit  ref_seen;
    int  last_ref;
    int  act_cyc [4];
    sdram_pkg::sdram_cmd_e cmd;

    tb_clock clkgen (.clk(clk), .rst(rst));

    sdram_ctrl dut (
        .clk(clk), .rst(rst), .req_valid(req_valid), .req(req),
        .credit_return(credit_return), .rd_valid(rd_valid), .rd_data(rd_data),
        .init_done(init_done), .sdram_bus(sdram_bus), .dq_out(dq_out),
        .dq_oe(dq_oe), .dq_in(dq_in)
    );

    tb_sdram_model mem_model (
        .clk(clk), .rst(rst), .bus(sdram_bus), .dq_out(dq_out), .dq_oe(dq_oe), .dq_in(dq_in)
    );

    task automatic report_error(input string msg);
        $display("Error: %0t ns: %s", $time, msg);
        $display("TEST RESULT: FAIL");
        $fatal(1);
    endtask

    function automatic logic [15:0] expected_fill(input logic [23:0] addr);
        return addr[15:0] ^ {addr[23:16], addr[23:16]} ^ 16'h5a3c;
    endfunction

    // one clock, collects returned credits, request low by default
    task automatic next_cycle();
        @(posedge clk);
        if (credit_return) credits++;
        assert (credits <= sdram_pkg::REQ_CREDITS)
            else report_error($sformatf("credit count %0d above limit", credits));
        req_valid <= 1'b0;
    endtask

    task automatic send_req(input logic we, input logic [1:0] ba, input logic [12:0] row,
                            input logic [8:0] col, input logic [15:0] wdata);
        logic [23:0] key;
        key = {ba, row, col};
        next_cycle();
        while (credits == 0) next_cycle();  // wait for a credit
        req_valid <= 1'b1;
        req       <= '{we: we, ba: ba, row: row, col: col, wdata: wdata};
        credits--;
        if (we) sb[key] = wdata;
        else exp_q.push_back(sb.exists(key) ? sb[key] : expected_fill(key));
    endtask

    // pin monitor, samples values registered at the previous edge
    always @(posedge clk) begin
        if (rst) begin
            cyc       = 0;
            init_step = 0;
            last_init = 0;
            done_seen = 1'b0;
            ref_seen  = 1'b0;
        end else begin
            cyc++;
            cmd = sdram_bus.cmd;
            assert (dq_oe == (cmd == sdram_pkg::CMD_WRITE))
                else report_error("dq_oe outside a WRITE cycle");
            if (!init_done) begin
                case (cmd)
                    sdram_pkg::CMD_NOP: begin
                    end
                    sdram_pkg::CMD_PRECHARGE: begin
                        assert (init_step == 0 && sdram_bus.a[10])
                            else report_error("bad init precharge");
                        init_step = 1;
                        last_init = cyc;
                    end
                    sdram_pkg::CMD_REFRESH: begin
                        assert ((init_step == 1 && cyc - last_init == sdram_pkg::T_RP + 1) ||
                                (init_step == 2 && cyc - last_init == sdram_pkg::T_RFC + 1))
                            else report_error("init refresh out of place");
                        init_step++;
                        last_init = cyc;
                    end
                    sdram_pkg::CMD_LOAD_MODE: begin
                        assert (init_step == 3 && cyc - last_init == sdram_pkg::T_RFC + 1 &&
                                sdram_bus.a == sdram_pkg::MODE_WORD)
                            else report_error("bad mode register load");
                        init_step = 4;
                        last_init = cyc;
                    end
                    default: report_error($sformatf("command %s during init", cmd.name()));
                endcase
            end else begin
                if (!done_seen) begin
                    assert (init_step == 4 && cyc - last_init == sdram_pkg::T_MRD + 1)
                        else report_error("init_done timing wrong");
                    done_seen = 1'b1;
                    last_ref  = cyc;  // refresh interval counted from here
                end
                assert (cmd == sdram_pkg::CMD_NOP || !ref_seen ||
                        cyc - last_ref > sdram_pkg::T_RFC)
                    else report_error("command inside refresh recovery");
                // gap up to and including this cycle
                assert (cyc - last_ref <= MAX_REF_GAP) else report_error("refresh overdue");
                case (cmd)
                    sdram_pkg::CMD_NOP: begin
                    end
                    sdram_pkg::CMD_REFRESH: begin
                        last_ref = cyc;
                        ref_seen = 1'b1;
                    end
                    sdram_pkg::CMD_ACTIVE: act_cyc[sdram_bus.ba] = cyc;
                    sdram_pkg::CMD_READ, sdram_pkg::CMD_WRITE: begin
                        assert (cyc - act_cyc[sdram_bus.ba] == sdram_pkg::T_RCD && sdram_bus.a[10])
                            else report_error("READ/WRITE not tRCD after ACTIVE or no A10");
                    end
                    default: report_error($sformatf("unexpected command %s", cmd.name()));
                endcase
            end
            assert (!credit_return || cmd == sdram_pkg::CMD_ACTIVE)
                else report_error("credit_return without ACTIVE");
            if (rd_valid) begin
                assert (exp_q.size() > 0) else report_error("rd_valid with no read pending");
                assert (rd_data == exp_q[0])
                    else report_error($sformatf("rd_data %h expected %h", rd_data, exp_q[0]));
                void'(exp_q.pop_front());
            end
        end
    end

    initial begin
        repeat (WD_CYCLES) @(posedge clk);
        $display("Timeout: the controller stopped making progress");
        $display("TEST RESULT: FAIL");
        $fatal(1);
    end

    initial begin
        seed      = 86;
        credits   = sdram_pkg::REQ_CREDITS;
        req_valid = 1'b0;
        req       = '0;
        @(negedge rst);
        while (!init_done) next_cycle();
        // directed writes, readback, one untouched word
        send_req(1'b1, 2'd0, 13'd5, 9'd1, 16'h1234);
        send_req(1'b1, 2'd1, 13'd7, 9'd2, 16'hbeef);
        send_req(1'b1, 2'd2, 13'd9, 9'd3, 16'h0f0f);
        send_req(1'b1, 2'd3, 13'd1, 9'd4, 16'hcafe);
        send_req(1'b0, 2'd0, 13'd5, 9'd1, 16'h0);
        send_req(1'b0, 2'd1, 13'd7, 9'd2, 16'h0);
        send_req(1'b0, 2'd2, 13'd9, 9'd3, 16'h0);
        send_req(1'b0, 2'd3, 13'd1, 9'd4, 16'h0);
        send_req(1'b0, 2'd3, 13'd100, 9'd300, 16'h0);
        // random mix over a small address set
        for (int i = 0; i < N_RANDOM; i++) begin
            if ({$random(seed)} % 4 == 0) next_cycle();
            send_req(1'({$random(seed)} % 2), 2'({$random(seed)} % 4),
                     13'({$random(seed)} % 3), 9'({$random(seed)} % 4), 16'($random(seed)));
        end
        // all credits back and all reads returned
        while (credits != sdram_pkg::REQ_CREDITS || exp_q.size() != 0) next_cycle();
        repeat (sdram_pkg::T_WR_AP + 4) next_cycle();
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

//--- tb_sdram_model.sv
`timescale 1ns/10ps
// behavioural SDRAM, CL2 burst 1

module tb_sdram_model (
    input  logic                  clk,
    input  logic                  rst,
    input  sdram_pkg::sdram_bus_t bus,
    input  logic [15:0]           dq_out,
    input  logic                  dq_oe,
    output logic [15:0]           dq_in
);

    logic [15:0] mem [logic [23:0]];  // keyed by {ba, row, col}
    logic [12:0] open_row [4];
    logic        rd_pend;             // read registered at last edge
    logic [23:0] rd_addr;

    // value of a location never written
    function automatic logic [15:0] fill_word(input logic [23:0] addr);
        return addr[15:0] ^ {addr[23:16], addr[23:16]} ^ 16'h5a3c;
    endfunction

    always @(posedge clk) begin
        if (rst) begin
            dq_in   <= '0;
            rd_pend = 1'b0;
        end else begin
            // data out one cycle after the READ edge, valid at the CL2 edge
            if (rd_pend) begin
                dq_in   <= mem.exists(rd_addr) ? mem[rd_addr] : fill_word(rd_addr);
                rd_pend = 1'b0;
            end
            case (bus.cmd)
                sdram_pkg::CMD_ACTIVE: begin
                    open_row[bus.ba] = bus.a;
                end
                sdram_pkg::CMD_WRITE: begin
                    if (dq_oe) begin
                        mem[{bus.ba, open_row[bus.ba], bus.a[8:0]}] = dq_out;
                    end
                end
                sdram_pkg::CMD_READ: begin
                    rd_addr = {bus.ba, open_row[bus.ba], bus.a[8:0]};
                    rd_pend = 1'b1;
                end
                default: begin
                end
            endcase
        end
    end

endmodule

//--- tb_clock.sv
`timescale 1ns/10ps
// testbench clock and reset

module tb_clock (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;  // 8 ns period
    end

    initial begin
        rst = 1'b1;
        repeat (4) @(posedge clk);
        rst <= 1'b0;  // released after 4 cycles
    end

endmodule

//--- sdram_ctrl.sv
`timescale 1ns/10ps
// SDRAM controller top level

module sdram_ctrl (
    input  logic                  clk,
    input  logic                  rst,
    // host side
    input  logic                  req_valid,
    input  sdram_pkg::host_req_t  req,
    output logic                  credit_return,
    output logic                  rd_valid,
    output logic [15:0]           rd_data,
    output logic                  init_done,
    // SDRAM pins
    output sdram_pkg::sdram_bus_t sdram_bus,
    output logic [15:0]           dq_out,
    output logic                  dq_oe,
    input  logic [15:0]           dq_in
);

    sdram_pkg::sdram_bus_t init_bus;   // power-up commands
    logic                  init_busy;
    logic                  refresh_req;
    logic                  refresh_ack;

    assign init_done = ~init_busy;

    sdram_init u_init (
        .clk       (clk),
        .rst       (rst),
        .init_bus  (init_bus),
        .init_busy (init_busy)
    );

    sdram_refresh u_refresh (
        .clk         (clk),
        .rst         (rst),
        .init_busy   (init_busy),
        .refresh_ack (refresh_ack),
        .refresh_req (refresh_req)
    );

    sdram_access u_access (
        .clk           (clk),
        .rst           (rst),
        .init_bus      (init_bus),
        .init_busy     (init_busy),
        .refresh_req   (refresh_req),
        .refresh_ack   (refresh_ack),
        .req_valid     (req_valid),
        .req           (req),
        .credit_return (credit_return),
        .rd_valid      (rd_valid),
        .rd_data       (rd_data),
        .sdram_bus     (sdram_bus),
        .dq_out        (dq_out),
        .dq_oe         (dq_oe),
        .dq_in         (dq_in)
    );

endmodule

//--- sdram_access.sv
`timescale 1ns/10ps
// SDRAM access sequencer
// request queue, command FSM, pin registers and read capture

module sdram_access (
    input  logic                  clk,
    input  logic                  rst,
    input  sdram_pkg::sdram_bus_t init_bus,
    input  logic                  init_busy,
    input  logic                  refresh_req,
    output logic                  refresh_ack,
    input  logic                  req_valid,
    input  sdram_pkg::host_req_t  req,
    output logic                  credit_return,
    output logic                  rd_valid,
    output logic [15:0]           rd_data,
    output sdram_pkg::sdram_bus_t sdram_bus,
    output logic [15:0]           dq_out,
    output logic                  dq_oe,
    input  logic [15:0]           dq_in
);

    sdram_pkg::host_req_t          queue [sdram_pkg::REQ_CREDITS];
    sdram_pkg::qptr_t              wr_ptr;
    sdram_pkg::qptr_t              rd_ptr;
    sdram_pkg::qcnt_t              q_count;
    sdram_pkg::host_req_t          cur;      // access in progress
    sdram_pkg::access_state_e      state;
    sdram_pkg::gap_cnt_t           gap_cnt;
    logic [sdram_pkg::CAS_LAT+1:0] rd_pipe;  // bit k set k cycles after READ on pins
    logic [15:0]                   dq_in_q;  // input pad register
    logic                          start_ref;
    logic                          start_acc;

    // refresh wins over the queue head
    assign start_ref = (state == sdram_pkg::ACC_IDLE) && !init_busy && refresh_req;
    assign start_acc = (state == sdram_pkg::ACC_IDLE) && !init_busy && !refresh_req &&
                       (q_count != '0);

    // credits keep the host from pushing into a full queue
    always_ff @(posedge clk) begin
        if (req_valid) begin
            queue[wr_ptr] <= req;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            q_count <= '0;
        end else begin
            if (req_valid) begin
                wr_ptr <= wr_ptr + sdram_pkg::qptr_t'(1);
            end
            if (start_acc) begin
                rd_ptr <= rd_ptr + sdram_pkg::qptr_t'(1);  // pop = credit back
            end
            q_count <= q_count + sdram_pkg::qcnt_t'(req_valid) - sdram_pkg::qcnt_t'(start_acc);
        end
    end

    always_ff @(posedge clk) begin
        if (start_acc) begin
            cur <= queue[rd_ptr];
        end
        if (state == sdram_pkg::ACC_RW && cur.we) begin
            dq_out <= cur.wdata;  // launched with WRITE
        end
        dq_in_q <= dq_in;
        if (rd_pipe[sdram_pkg::CAS_LAT+1]) begin
            rd_data <= dq_in_q;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state         <= sdram_pkg::ACC_IDLE;
            gap_cnt       <= '0;
            sdram_bus     <= sdram_pkg::BUS_NOP;
            dq_oe         <= 1'b0;
            refresh_ack   <= 1'b0;
            credit_return <= 1'b0;
            rd_pipe       <= '0;
            rd_valid      <= 1'b0;
        end else begin
            sdram_bus     <= init_busy ? init_bus : sdram_pkg::BUS_NOP;  // init owns the bus
            dq_oe         <= 1'b0;
            refresh_ack   <= 1'b0;
            credit_return <= 1'b0;
            rd_pipe       <= {rd_pipe[sdram_pkg::CAS_LAT:0], 1'b0};
            rd_valid      <= rd_pipe[sdram_pkg::CAS_LAT+1];
            case (state)
                sdram_pkg::ACC_IDLE: begin
                    if (start_ref) begin
                        sdram_bus.cmd <= sdram_pkg::CMD_REFRESH;
                        refresh_ack   <= 1'b1;
                        gap_cnt       <= sdram_pkg::gap_cnt_t'(sdram_pkg::T_RFC - 1);
                        state         <= sdram_pkg::ACC_REFRESH_WAIT;
                    end else if (start_acc) begin
                        sdram_bus.cmd <= sdram_pkg::CMD_ACTIVE;  // open the row
                        sdram_bus.ba  <= queue[rd_ptr].ba;
                        sdram_bus.a   <= queue[rd_ptr].row;
                        credit_return <= 1'b1;
                        // last tRCD cycle is spent in ACC_RW
                        gap_cnt       <= sdram_pkg::gap_cnt_t'(sdram_pkg::T_RCD - 2);
                        state         <= sdram_pkg::ACC_ACTIVE_WAIT;
                    end
                end
                sdram_pkg::ACC_ACTIVE_WAIT: begin
                    if (gap_cnt == '0) begin
                        state <= sdram_pkg::ACC_RW;
                    end else begin
                        gap_cnt <= gap_cnt - sdram_pkg::gap_cnt_t'(1);
                    end
                end
                sdram_pkg::ACC_RW: begin
                    sdram_bus.ba <= cur.ba;
                    sdram_bus.a  <= {2'b00, 1'b1, 1'b0, cur.col};  // A10 auto-precharge
                    if (cur.we) begin
                        sdram_bus.cmd <= sdram_pkg::CMD_WRITE;
                        dq_oe         <= 1'b1;
                        gap_cnt       <= sdram_pkg::gap_cnt_t'(sdram_pkg::T_WR_AP - 1);
                    end else begin
                        sdram_bus.cmd <= sdram_pkg::CMD_READ;
                        rd_pipe[0]    <= 1'b1;  // data returns later, FSM moves on
                        gap_cnt       <= sdram_pkg::gap_cnt_t'(sdram_pkg::T_RP - 1);
                    end
                    state <= sdram_pkg::ACC_PRECHARGE_WAIT;
                end
                sdram_pkg::ACC_PRECHARGE_WAIT, sdram_pkg::ACC_REFRESH_WAIT: begin
                    if (gap_cnt == '0) begin
                        state <= sdram_pkg::ACC_IDLE;
                    end else begin
                        gap_cnt <= gap_cnt - sdram_pkg::gap_cnt_t'(1);
                    end
                end
                default: begin
                    state <= sdram_pkg::ACC_IDLE;
                end
            endcase
        end
    end

endmodule

//--- sdram_refresh.sv
`timescale 1ns/10ps
// SDRAM periodic refresh timer

module sdram_refresh (
    input  logic clk,
    input  logic rst,
    input  logic init_busy,
    input  logic refresh_ack,
    output logic refresh_req
);

    sdram_pkg::ref_cnt_t cnt;  // cycles until next refresh is due

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cnt         <= sdram_pkg::ref_cnt_t'(sdram_pkg::REFRESH_INTERVAL - 1);
            refresh_req <= 1'b0;
        end else if (init_busy) begin
            // init runs its own refreshes
            cnt <= sdram_pkg::ref_cnt_t'(sdram_pkg::REFRESH_INTERVAL - 1);
        end else if (refresh_ack) begin
            // interval restarts from the issued refresh
            cnt         <= sdram_pkg::ref_cnt_t'(sdram_pkg::REFRESH_INTERVAL - 1);
            refresh_req <= 1'b0;
        end else if (cnt == '0) begin
            refresh_req <= 1'b1;  // sticky until ack, counter parks at zero
        end else begin
            cnt <= cnt - sdram_pkg::ref_cnt_t'(1);
        end
    end

endmodule

//--- sdram_init.sv
`timescale 1ns/10ps
// SDRAM power-up sequencer

module sdram_init (
    input  logic                  clk,
    input  logic                  rst,
    output sdram_pkg::sdram_bus_t init_bus,
    output logic                  init_busy
);

    sdram_pkg::init_state_e state;
    sdram_pkg::init_cnt_t   wait_cnt;  // NOP cycles left before next step

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= sdram_pkg::INIT_WAIT_ST;
            wait_cnt  <= sdram_pkg::init_cnt_t'(sdram_pkg::POWERUP_WAIT - 1);
            init_bus  <= sdram_pkg::BUS_NOP;
            init_busy <= 1'b1;
        end else begin
            init_bus <= sdram_pkg::BUS_NOP;  // each command lasts one cycle
            if (wait_cnt != '0) begin
                wait_cnt <= wait_cnt - sdram_pkg::init_cnt_t'(1);
            end else begin
                case (state)
                    sdram_pkg::INIT_WAIT_ST: begin
                        // precharge all banks
                        init_bus.cmd   <= sdram_pkg::CMD_PRECHARGE;
                        init_bus.a[10] <= 1'b1;
                        wait_cnt       <= sdram_pkg::init_cnt_t'(sdram_pkg::T_RP);
                        state          <= sdram_pkg::INIT_PRECHARGE;
                    end
                    sdram_pkg::INIT_PRECHARGE: begin
                        init_bus.cmd <= sdram_pkg::CMD_REFRESH;  // first auto-refresh
                        wait_cnt     <= sdram_pkg::init_cnt_t'(sdram_pkg::T_RFC);
                        state        <= sdram_pkg::INIT_REFRESH1;
                    end
                    sdram_pkg::INIT_REFRESH1: begin
                        init_bus.cmd <= sdram_pkg::CMD_REFRESH;  // second one
                        wait_cnt     <= sdram_pkg::init_cnt_t'(sdram_pkg::T_RFC);
                        state        <= sdram_pkg::INIT_REFRESH2;
                    end
                    sdram_pkg::INIT_REFRESH2: begin
                        init_bus.cmd <= sdram_pkg::CMD_LOAD_MODE;
                        init_bus.a   <= sdram_pkg::MODE_WORD;
                        wait_cnt     <= sdram_pkg::init_cnt_t'(sdram_pkg::T_MRD);
                        state        <= sdram_pkg::INIT_MODE;
                    end
                    sdram_pkg::INIT_MODE: begin
                        // one more step since the access block registers the pins
                        state <= sdram_pkg::INIT_DONE;
                    end
                    sdram_pkg::INIT_DONE: begin
                        init_busy <= 1'b0;  // hand the bus over, stays here
                    end
                    default: begin
                        state <= sdram_pkg::INIT_DONE;
                    end
                endcase
            end
        end
    end

endmodule

//--- sdram_pkg.sv
// SDRAM controller shared definitions
// commands, states, timing and bus bundles

package sdram_pkg;

    // timing, all counts in clk cycles
    localparam int POWERUP_WAIT     = 200;  // cut down for simulation
    localparam int T_RP             = 2;    // precharge to next command
    localparam int T_RFC            = 11;   // refresh to next command
    localparam int T_MRD            = 3;    // mode load to next command
    localparam int T_RCD            = 2;    // active to read/write
    localparam int CAS_LAT          = 2;
    localparam int T_WR_AP          = 4;    // write recovery incl. auto-precharge
    localparam int REFRESH_INTERVAL = 390;
    localparam int REQ_CREDITS      = 2;    // queue depth = host credits

    // A12..A0: reserved, write burst mode, op mode, CL=2, sequential, BL=1
    localparam logic [12:0] MODE_WORD = 13'b000_0_00_010_0_000;

    localparam int INIT_CNT_W = $clog2(POWERUP_WAIT + 1);
    localparam int REF_CNT_W  = $clog2(REFRESH_INTERVAL + 1);
    localparam int GAP_CNT_W  = $clog2(T_RFC + 1);  // refresh gap is the longest
    localparam int QPTR_W     = $clog2(REQ_CREDITS); // depth must be a power of two
    localparam int QCNT_W     = $clog2(REQ_CREDITS + 1);

    typedef logic [INIT_CNT_W-1:0] init_cnt_t;
    typedef logic [REF_CNT_W-1:0]  ref_cnt_t;
    typedef logic [GAP_CNT_W-1:0]  gap_cnt_t;
    typedef logic [QPTR_W-1:0]     qptr_t;
    typedef logic [QCNT_W-1:0]     qcnt_t;

    // /CS /RAS /CAS /WE
    typedef enum logic [3:0] {
        CMD_LOAD_MODE = 4'b0000,
        CMD_REFRESH   = 4'b0001,
        CMD_PRECHARGE = 4'b0010,
        CMD_ACTIVE    = 4'b0011,
        CMD_WRITE     = 4'b0100,
        CMD_READ      = 4'b0101,
        CMD_STOP      = 4'b0110,  // burst terminate
        CMD_NOP       = 4'b0111,
        CMD_INHIBIT   = 4'b1000   // chip deselected
    } sdram_cmd_e;

    // command/address bundle at the pins
    typedef struct packed {
        sdram_cmd_e  cmd;
        logic [1:0]  ba;
        logic [12:0] a;
    } sdram_bus_t;

    localparam sdram_bus_t BUS_NOP = '{cmd: CMD_NOP, ba: 2'd0, a: 13'd0};

    // one host word access
    typedef struct packed {
        logic        we;     // 1 = write
        logic [1:0]  ba;
        logic [12:0] row;
        logic [8:0]  col;
        logic [15:0] wdata;
    } host_req_t;

    typedef enum logic [2:0] {
        INIT_WAIT_ST, INIT_PRECHARGE, INIT_REFRESH1, INIT_REFRESH2, INIT_MODE, INIT_DONE
    } init_state_e;

    typedef enum logic [2:0] {
        ACC_IDLE, ACC_ACTIVE_WAIT, ACC_RW, ACC_PRECHARGE_WAIT, ACC_REFRESH_WAIT
    } access_state_e;

endpackage
